/* copUnit.f */
design/copPkg.sv
design/copRegIf.sv
design/copIf.sv
design/copIfBus.sv
design/copRegBank.sv
design/copUnit.sv
tb/copUnit_properties.sv
tb/copUnitTb.sv

/* Bender.yml */
package:
  name: cop_unit

sources:
  - design/copPkg.sv
  - design/copRegIf.sv
  - design/copIf.sv
  - design/copIfBus.sv
  - design/copRegBank.sv
  - design/copUnit.sv
  - target: test
    files:
      - tb/copUnit_properties.sv
      - tb/copUnitTb.sv

/* tb/copUnitTb.sv */
module copUnitTb import copPkg::*; ();

  localparam int CycleLimit = 600;  // about twice the directed tests

  logic    sysClk;
  logic    arstN;
  instT    instIf;
  logic    iStallIf;
  logic    exception;
  haltVecT haltR;
  wordT    dbusMUpIn;
  wordT    dbusMDownIn;
  wordT    dbusMUpOut;
  wordT    dbusMDownOut;
  logic    rHold;
  logic    cpCondN;

  integer seed;
  int     cycleCnt;
  logic   holdSeen;
  wordT   genModel [NumCopRegs];  // expected bank contents
  wordT   conModel [NumCopRegs];

  copUnit u_dut (
    .sysClk       (sysClk),
    .arstN        (arstN),
    .instIf       (instIf),
    .iStallIf     (iStallIf),
    .exception    (exception),
    .haltR        (haltR),
    .dbusMUpIn    (dbusMUpIn),
    .dbusMDownIn  (dbusMDownIn),
    .dbusMUpOut   (dbusMUpOut),
    .dbusMDownOut (dbusMDownOut),
    .rHold        (rHold),
    .cpCondN      (cpCondN)
  );

  always #4 sysClk = ~sysClk;

  always @(posedge sysClk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= CycleLimit) begin
      $display("timeout: the tests did not finish within %0d cycles", CycleLimit);
      $display("*** TEST FAILED ***");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic checkVal(input string name, input wordT act, input wordT exp);
    if (act !== exp) begin
      $display("error: time %0t signal %s actual %h expected %h", $time, name, act, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // rd names the register for the moves
  function automatic instT copInst(input logic [1:0] unitNo, input logic [4:0] rs,
                                   input regAddrT rd);
    return {OpcCop, unitNo, rs, 5'd0, rd, 11'd0};
  endfunction

  function automatic instT memInst(input logic [3:0] opc, input regAddrT rt);
    return {opc, CopUnitNo, 5'd3, rt, 16'h0040};  // base and offset are ignored here
  endfunction

  // all tasks start and end at a rising edge
  task automatic issueInst(input instT inst);
    logic held;
    instIf   <= inst;
    iStallIf <= 1'b0;
    do begin
      @(negedge sysClk);
      held = rHold || (haltR != '0);
      @(posedge sysClk);
    end while (held);
    instIf   <= '0;
    iStallIf <= 1'b1;
  endtask

  task automatic driveDataBus(input logic useUp, input wordT val);
    wordT other;
    other = $random(seed);
    dbusMUpIn   <= useUp ? val : other;
    dbusMDownIn <= useUp ? other : val;
  endtask

  task automatic writeReg(input instT inst, input logic useUp, input wordT val);
    issueInst(inst);
    @(posedge sysClk);  // write now in M
    driveDataBus(useUp, val);
    @(posedge sysClk);
  endtask

  // waits out any hold in E, then checks both halves in the M cycle
  task automatic expectRead(input wordT exp);
    logic held;
    holdSeen = 1'b0;
    do begin
      @(negedge sysClk);
      held = rHold || (haltR != '0);
      if (rHold) holdSeen = 1'b1;
      @(posedge sysClk);
    end while (held);
    dbusMUpIn   <= $random(seed);
    dbusMDownIn <= $random(seed);
    @(negedge sysClk);
    checkVal("dbusMUpOut", dbusMUpOut, exp);
    checkVal("dbusMDownOut", dbusMDownOut, exp);
    @(posedge sysClk);
  endtask

  task automatic checkPassThrough(input int n);
    wordT upV;
    wordT downV;
    repeat (n) begin
      upV = $random(seed);
      downV = $random(seed);
      dbusMUpIn   <= upV;
      dbusMDownIn <= downV;
      @(negedge sysClk);
      checkVal("dbusMUpOut", dbusMUpOut, upV);
      checkVal("dbusMDownOut", dbusMDownOut, downV);
      @(posedge sysClk);
    end
  endtask

  task automatic resetState();
    @(negedge sysClk);
    checkVal("rHold", rHold, 0);
    checkVal("cpCondN", cpCondN, 1);
    @(posedge sysClk);
    checkPassThrough(4);
  endtask

  task automatic moveRoundTrip();
    wordT val;
    val = $random(seed);
    writeReg(copInst(CopUnitNo, RsMt, 5'd5), 1'b0, val);
    genModel[5] = val;
    repeat (2) @(posedge sysClk);
    issueInst(copInst(CopUnitNo, RsMf, 5'd5));
    expectRead(genModel[5]);
    issueInst(copInst(CopUnitNo, RsCf, 5'd5));
    expectRead(conModel[5]);  // control space is separate
    writeReg(copInst(2'd1, RsMt, 5'd5), 1'b0, ~val);  // COP1, not ours
    repeat (2) @(posedge sysClk);
    issueInst(copInst(CopUnitNo, RsMf, 5'd5));
    expectRead(genModel[5]);
  endtask

  task automatic condFlag(input wordT val);
    logic condExp;
    writeReg(copInst(CopUnitNo, RsCt, 5'd0), 1'b0, val);
    conModel[0] = val;
    condExp = ~conModel[0][0];
    repeat (3) @(posedge sysClk);  // W, bank update, flag register
    @(negedge sysClk);
    checkVal("cpCondN", cpCondN, condExp);
    @(posedge sysClk);
  endtask

  task automatic hazardForward(input instT wrInst, input instT rdInst, input logic useUp,
                               input regAddrT addr);
    wordT val;
    val = $random(seed);
    issueInst(wrInst);
    issueInst(rdInst);
    driveDataBus(useUp, val);  // write is in M here
    genModel[addr] = val;
    expectRead(genModel[addr]);
    checkVal("rHold seen", holdSeen, 1);
  endtask

  task automatic exceptionKill();
    wordT oldVal;
    oldVal = $random(seed);
    writeReg(copInst(CopUnitNo, RsMt, 5'd7), 1'b0, oldVal);
    genModel[7] = oldVal;
    issueInst(copInst(CopUnitNo, RsMt, 5'd7));
    @(posedge sysClk);
    driveDataBus(1'b0, ~oldVal);
    exception <= 1'b1;
    @(posedge sysClk);
    exception <= 1'b0;
    repeat (2) @(posedge sysClk);
    issueInst(copInst(CopUnitNo, RsMf, 5'd7));
    expectRead(genModel[7]);
  endtask

  task automatic haltGating();
    wordT    val;
    haltVecT hv;
    val = $random(seed);
    hv = '0;
    hv[HaltDcM] = 1'b1;
    writeReg(copInst(CopUnitNo, RsMt, 5'd12), 1'b0, val);
    genModel[12] = val;
    repeat (2) @(posedge sysClk);
    issueInst(copInst(CopUnitNo, RsMf, 5'd12));
    @(posedge sysClk);  // read in M, frozen by the halt
    haltR <= hv;
    checkPassThrough(3);
    haltR <= '0;
    @(negedge sysClk);
    checkVal("dbusMUpOut", dbusMUpOut, genModel[12]);
    checkVal("dbusMDownOut", dbusMDownOut, genModel[12]);
    @(posedge sysClk);
  endtask

  initial begin
    seed = 26982;
    cycleCnt = 0;
    holdSeen = 1'b0;
    sysClk = 1'b0;
    arstN = 1'b0;
    instIf = '0;
    iStallIf = 1'b1;
    exception = 1'b0;
    haltR = '0;
    dbusMUpIn = '0;
    dbusMDownIn = '0;
    for (int r = 0; r < NumCopRegs; r++) begin
      genModel[r] = '0;
      conModel[r] = '0;
    end
    repeat (5) @(posedge sysClk);
    arstN <= 1'b1;
    resetState();
    moveRoundTrip();
    condFlag(32'd1);
    condFlag(32'd0);
    hazardForward(copInst(CopUnitNo, RsMt, 5'd20), copInst(CopUnitNo, RsMf, 5'd20),
                  1'b0, 5'd20);
    hazardForward(memInst(OpcLwc, 5'd21), memInst(OpcSwc, 5'd21), 1'b1, 5'd21);
    exceptionKill();
    haltGating();
    if (u_dut.u_copIfBus.u_props.propFails == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("%0d assertion failures were seen", u_dut.u_copIfBus.u_props.propFails);
      $display("*** TEST FAILED ***");
      $fatal(1, "assertions failed during the run");
    end
  end

endmodule

/* tb/copUnit_properties.sv */
module copUnitProperties import copPkg::*; (
  input logic    sysClk,
  input logic    arstN,
  input haltVecT haltR,
  input wordT    dbusMUpIn,
  input wordT    dbusMDownIn,
  input wordT    dbusMUpOut,
  input wordT    dbusMDownOut,
  input logic    rHold,
  input logic    cwrGen,
  input logic    cwrCon,
  input copOpT   opM
);

  int   propFails = 0;
  logic dcHalt;

  assign dcHalt = haltR[HaltDcM] | haltR[HaltDcW] | haltR[HaltDwW];

  oneWriteSpace: assert property (@(posedge sysClk) disable iff (!arstN)
    !(cwrGen && cwrCon))
    else begin
      propFails++;
      $error("general and control write enables high together");
    end

  // the data cache owns the bus while halted
  busPassOnHalt: assert property (@(posedge sysClk) disable iff (!arstN)
    dcHalt |-> (dbusMUpOut == dbusMUpIn) && (dbusMDownOut == dbusMDownIn))
    else begin
      propFails++;
      $error("bus output differs from its input during a data cache halt");
    end

  holdNeedsWrite: assert property (@(posedge sysClk) disable iff (!arstN)
    rHold |-> (opM == OpMt) || (opM == OpCt) || (opM == OpLwc))
    else begin
      propFails++;
      $error("rHold high without a write in M");
    end

endmodule

bind copIfBus copUnitProperties u_props (
  .sysClk       (sysClk),
  .arstN        (arstN),
  .haltR        (haltR),
  .dbusMUpIn    (dbusMUpIn),
  .dbusMDownIn  (dbusMDownIn),
  .dbusMUpOut   (dbusMUpOut),
  .dbusMDownOut (dbusMDownOut),
  .rHold        (rHold),
  .cwrGen       (regIf.cwrGen),
  .cwrCon       (regIf.cwrCon),
  .opM          (u_copIf.opM)
);

/* design/copUnit.sv */
module copUnit import copPkg::*; (
  input  logic    sysClk,
  input  logic    arstN,
  input  instT    instIf,
  input  logic    iStallIf,
  input  logic    exception,
  input  haltVecT haltR,
  input  wordT    dbusMUpIn,
  input  wordT    dbusMDownIn,
  output wordT    dbusMUpOut,
  output wordT    dbusMDownOut,
  output logic    rHold,
  output logic    cpCondN
);

  logic condInN;  // bank flag back to the interface

  copRegIf regIf ();

  copIfBus u_copIfBus (
    .sysClk       (sysClk),
    .arstN        (arstN),
    .instIf       (instIf),
    .iStallIf     (iStallIf),
    .exception    (exception),
    .haltR        (haltR),
    .dbusMUpIn    (dbusMUpIn),
    .dbusMDownIn  (dbusMDownIn),
    .condInN      (condInN),
    .dbusMUpOut   (dbusMUpOut),
    .dbusMDownOut (dbusMDownOut),
    .rHold        (rHold),
    .cpCondN      (cpCondN),
    .regIf        (regIf.cop)
  );

  // stand-in for the real coprocessor
  copRegBank u_copRegBank (
    .sysClk  (sysClk),
    .arstN   (arstN),
    .condInN (condInN),
    .regIf   (regIf.bank)
  );

endmodule

/* design/copRegBank.sv */
module copRegBank import copPkg::*; (
  input  logic  sysClk,
  input  logic  arstN,
  output logic  condInN,
  copRegIf.bank regIf
);

  // index 0 is the general space, index 1 the control space
  wordT regs [2][NumCopRegs];

  always_comb begin
    if (regIf.crdGen | regIf.crdCon) begin
      regIf.crdData = regs[regIf.crdCon][regIf.crdAddr];
    end else begin
      regIf.crdData = '0;
    end
  end

  always_ff @(posedge sysClk or negedge arstN) begin
    if (!arstN) begin
      for (int s = 0; s < 2; s++) begin
        for (int r = 0; r < NumCopRegs; r++) begin
          regs[s][r] <= '0;
        end
      end
    end else if (regIf.cwrGen | regIf.cwrCon) begin
      regs[regIf.cwrCon][regIf.cwrAddr] <= regIf.cwrData;  // control space when cwrCon
    end
  end

  // condition flag lives in bit 0 of control register 0
  assign condInN = ~regs[1][0][0];

endmodule

/* design/copIfBus.sv */
module copIfBus import copPkg::*; (
  input  logic    sysClk,
  input  logic    arstN,
  input  instT    instIf,
  input  logic    iStallIf,
  input  logic    exception,
  input  haltVecT haltR,
  input  wordT    dbusMUpIn,
  input  wordT    dbusMDownIn,
  input  logic    condInN,
  output wordT    dbusMUpOut,
  output wordT    dbusMDownOut,
  output logic    rHold,
  output logic    cpCondN,
  copRegIf.cop    regIf
);

  logic cMemOpM;
  logic cDriverM;
  wordT crdDataM;
  wordT dbusCopIn;
  logic dcHalt;
  logic driveBus;

  copIf u_copIf (
    .sysClk    (sysClk),
    .arstN     (arstN),
    .instIf    (instIf),
    .iStallIf  (iStallIf),
    .exception (exception),
    .haltR     (haltR),
    .dbusM     (dbusCopIn),
    .condInN   (condInN),
    .cMemOpM   (cMemOpM),
    .cDriverM  (cDriverM),
    .crdDataM  (crdDataM),
    .rHold     (rHold),
    .cpCondN   (cpCondN),
    .regIf     (regIf)
  );

  // any data side halt means the bus is not ours this cycle
  assign dcHalt = haltR[HaltDcM] | haltR[HaltDcW] | haltR[HaltDwW];

  // loads and stores use the up half, moves the down half
  assign dbusCopIn = (cMemOpM | dcHalt) ? dbusMUpIn : dbusMDownIn;

  assign driveBus = cDriverM & ~dcHalt;

  assign dbusMUpOut   = driveBus ? crdDataM : dbusMUpIn;
  assign dbusMDownOut = driveBus ? crdDataM : dbusMDownIn;  // same data on both halves

endmodule

/* design/copIf.sv */
module copIf import copPkg::*; (
  input  logic    sysClk,
  input  logic    arstN,
  input  instT    instIf,
  input  logic    iStallIf,
  input  logic    exception,
  input  haltVecT haltR,
  input  wordT    dbusM,
  input  logic    condInN,
  output logic    cMemOpM,
  output logic    cDriverM,
  output wordT    crdDataM,
  output logic    rHold,
  output logic    cpCondN,
  copRegIf.cop    regIf
);

  copOpT   decOp;
  regAddrT decAddr;
  copOpT   opE;
  copOpT   opM;
  copOpT   opW;
  regAddrT addrE;
  regAddrT addrM;
  regAddrT addrW;
  wordT    dataM;   // read data, driven to the bus in M
  wordT    dataW;   // write data taken from the bus in M
  wordT    rdDataE;
  logic    advance;
  logic    excPend;
  logic    kill;
  logic    fwdW;

  function automatic logic readsGen(copOpT op);
    return (op == OpMf) || (op == OpSwc);
  endfunction

  function automatic logic readsCon(copOpT op);
    return op == OpCf;
  endfunction

  function automatic logic writesGen(copOpT op);
    return (op == OpMt) || (op == OpLwc);
  endfunction

  function automatic logic writesCon(copOpT op);
    return op == OpCt;
  endfunction

  // COPz moves name the register in rd, LWCz and SWCz in rt
  always_comb begin
    decOp   = OpNone;
    decAddr = instIf[15:11];
    if (instIf[27:26] == CopUnitNo) begin
      case (instIf[31:28])
        OpcCop: begin
          case (instIf[25:21])
            RsMf:    decOp = OpMf;
            RsCf:    decOp = OpCf;
            RsMt:    decOp = OpMt;
            RsCt:    decOp = OpCt;
            default: decOp = OpNone;
          endcase
        end
        OpcLwc: begin
          decOp   = OpLwc;
          decAddr = instIf[20:16];
        end
        OpcSwc: begin
          decOp   = OpSwc;
          decAddr = instIf[20:16];
        end
        default: decOp = OpNone;
      endcase
    end
  end

  assign advance = ~(haltR[HaltIc] | haltR[HaltDcM] | haltR[HaltDcW] | haltR[HaltDwW]);
  assign kill    = exception | excPend;

  // E read against M write of the same register, one cycle of hold
  assign rHold = ((readsGen(opE) & writesGen(opM)) | (readsCon(opE) & writesCon(opM)))
                 & (addrE == addrM);

  // W write still in flight, bypass the bank
  assign fwdW = ((readsGen(opE) & regIf.cwrGen) | (readsCon(opE) & regIf.cwrCon))
                & (addrE == addrW);
  assign rdDataE = fwdW ? regIf.cwrData : regIf.crdData;

  assign regIf.crdAddr = addrE;
  assign regIf.crdGen  = readsGen(opE);
  assign regIf.crdCon  = readsCon(opE);
  assign regIf.cwrAddr = addrW;
  assign regIf.cwrGen  = writesGen(opW);
  assign regIf.cwrCon  = writesCon(opW);
  assign regIf.cwrData = dataW;

  assign cMemOpM  = (opM == OpLwc) || (opM == OpSwc);
  assign cDriverM = readsGen(opM) | readsCon(opM);
  assign crdDataM = dataM;

  // an exception seen while halted waits for the next advance
  always_ff @(posedge sysClk or negedge arstN) begin
    if (!arstN) begin
      excPend <= 1'b0;
    end else if (advance) begin
      excPend <= 1'b0;
    end else if (exception) begin
      excPend <= 1'b1;
    end
  end

  always_ff @(posedge sysClk or negedge arstN) begin
    if (!arstN) begin
      opE <= OpNone;
      opM <= OpNone;
      opW <= OpNone;
    end else if (advance) begin
      if (kill) begin
        opE <= OpNone;
      end else if (!rHold) begin
        opE <= iStallIf ? OpNone : decOp;
      end
      opM <= (kill | rHold) ? OpNone : opE;  // bubble behind a held read
      opW <= kill ? OpNone : opM;             // killed op in M never writes
    end
  end

  always_ff @(posedge sysClk) begin
    if (advance) begin
      if (!rHold) begin
        addrE <= decAddr;
      end
      addrM <= addrE;
      dataM <= rdDataE;
      addrW <= addrM;
      dataW <= dbusM;
    end
  end

  always_ff @(posedge sysClk or negedge arstN) begin
    if (!arstN) begin
      cpCondN <= 1'b1;
    end else begin
      cpCondN <= condInN;
    end
  end

endmodule

/* design/copRegIf.sv */
interface copRegIf import copPkg::*; ();

  regAddrT crdAddr;
  logic    crdGen;   // read general space
  logic    crdCon;   // read control space
  wordT    crdData;

  regAddrT cwrAddr;
  logic    cwrGen;
  logic    cwrCon;
  wordT    cwrData;

  modport cop (
    output crdAddr, crdGen, crdCon,
    input  crdData,
    output cwrAddr, cwrGen, cwrCon, cwrData
  );

  modport bank (
    input  crdAddr, crdGen, crdCon,
    output crdData,
    input  cwrAddr, cwrGen, cwrCon, cwrData
  );

endinterface

/* design/copPkg.sv */
package copPkg;

  typedef logic [31:0] wordT;
  typedef logic [31:0] instT;
  typedef logic [4:0]  regAddrT;
  typedef logic [3:0]  haltVecT;
  typedef logic [2:0]  copOpT;

  localparam int NumCopRegs = 32;  // per register space

  // bit positions in haltVecT
  localparam int HaltIc  = 0;  // icache miss
  localparam int HaltDcM = 1;  // dcache halt in M
  localparam int HaltDcW = 2;  // dcache halt in W
  localparam int HaltDwW = 3;  // write buffer full

  // decoded op kinds
  localparam copOpT OpNone = 3'd0;
  localparam copOpT OpMf   = 3'd1;
  localparam copOpT OpCf   = 3'd2;
  localparam copOpT OpMt   = 3'd3;
  localparam copOpT OpCt   = 3'd4;
  localparam copOpT OpLwc  = 3'd5;
  localparam copOpT OpSwc  = 3'd6;

  // this unit answers as COP2
  localparam logic [1:0] CopUnitNo = 2'd2;

  // upper opcode bits 31:28
  // the low two opcode bits hold the unit number
  localparam logic [3:0] OpcCop = 4'b0100;
  localparam logic [3:0] OpcLwc = 4'b1100;
  localparam logic [3:0] OpcSwc = 4'b1110;

  // rs field of the COPz moves
  localparam logic [4:0] RsMf = 5'b00000;
  localparam logic [4:0] RsCf = 5'b00010;
  localparam logic [4:0] RsMt = 5'b00100;
  localparam logic [4:0] RsCt = 5'b00110;

endpackage
